// File: source/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] coord_t;
    typedef logic [15:0] colour_t;
    typedef logic [2:0]  reg_addr_t;

    // panel commands used by the fill
    localparam byte_t CMD_CASET = 8'h2A;
    localparam byte_t CMD_PASET = 8'h2B;
    localparam byte_t CMD_RAMWR = 8'h2C;

    localparam reg_addr_t REG_X0     = 3'd0;
    localparam reg_addr_t REG_X1     = 3'd1;
    localparam reg_addr_t REG_Y0     = 3'd2;
    localparam reg_addr_t REG_Y1     = 3'd3;
    localparam reg_addr_t REG_COLOUR = 3'd4;

    typedef struct packed {
        coord_t  x0;
        coord_t  x1;
        coord_t  y0;
        coord_t  y1;
        colour_t colour;
    } win_cfg_t;

    typedef struct packed {
        byte_t       cmd;
        logic [31:0] params;    // first byte on top
        logic [2:0]  n_params;
        logic        data_only; // no command byte, dcx high throughout
    } bus_req_t;

    typedef struct packed {
        logic  csx;
        logic  dcx;
        logic  wrx;
        byte_t data;
    } lcd_bus_t;

endpackage

`default_nettype wire

// File: source/lcd_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_cfg_regs (
    input  logic               clk,
    input  logic               nrst,
    input  logic               cfg_wr,
    input  lcd_pkg::reg_addr_t cfg_addr,
    input  logic [15:0]        cfg_wdata,
    input  logic               busy,
    output lcd_pkg::win_cfg_t  cfg
);

    logic wr_en;

    assign wr_en = cfg_wr && !busy; // window frozen during a fill

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (cfg_addr)
                lcd_pkg::REG_X0: begin
                    cfg.x0 <= cfg_wdata;
                end
                lcd_pkg::REG_X1: begin
                    cfg.x1 <= cfg_wdata;
                end
                lcd_pkg::REG_Y0: begin
                    cfg.y0 <= cfg_wdata;
                end
                lcd_pkg::REG_Y1: begin
                    cfg.y1 <= cfg_wdata;
                end
                lcd_pkg::REG_COLOUR: begin
                    cfg.colour <= cfg_wdata;
                end
                default: begin
                    // unmapped address, write dropped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/lcd_bus_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer (
    input  logic              clk,
    input  logic              nrst,
    input  logic              req_start,
    input  lcd_pkg::bus_req_t req,
    output logic              wr_busy,
    output logic              wr_done,
    output lcd_pkg::lcd_bus_t bus
);

    typedef enum logic [2:0] {
        IDLE,
        CMD_LOW,
        CMD_HIGH,
        PAR_LOW,
        PAR_HIGH,
        DONE
    } state_t;

    state_t      state;
    logic [31:0] par_q;    // remaining params, next byte on top
    logic [2:0]  cnt_q;    // params still to send

    assign wr_busy = (state != IDLE);
    assign wr_done = (state == DONE);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= IDLE;
            par_q    <= '0;
            cnt_q    <= '0;
            bus.csx  <= 1'b1;
            bus.dcx  <= 1'b0;
            bus.wrx  <= 1'b1;
            bus.data <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_start) begin
                        bus.csx <= 1'b0;
                        bus.wrx <= 1'b0;
                        if (req.data_only) begin
                            state    <= PAR_LOW;
                            bus.dcx  <= 1'b1;
                            bus.data <= req.params[31:24];
                            par_q    <= {req.params[23:0], 8'h00};
                            cnt_q    <= req.n_params - 3'd1;
                        end else begin
                            state    <= CMD_LOW;
                            bus.dcx  <= 1'b0;   // command byte
                            bus.data <= req.cmd;
                            par_q    <= req.params;
                            cnt_q    <= req.n_params;
                        end
                    end
                end
                CMD_LOW, PAR_LOW: begin
                    bus.wrx <= 1'b1; // panel latches on this edge
                    state   <= (state == CMD_LOW) ? CMD_HIGH : PAR_HIGH;
                end
                CMD_HIGH, PAR_HIGH: begin
                    if (cnt_q == 3'd0) begin
                        state   <= DONE;
                        bus.csx <= 1'b1;
                    end else begin
                        state    <= PAR_LOW;
                        bus.wrx  <= 1'b0;
                        bus.dcx  <= 1'b1;
                        bus.data <= par_q[31:24];
                        par_q    <= {par_q[23:0], 8'h00};
                        cnt_q    <= cnt_q - 3'd1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/lcd_fill_seq.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_fill_seq #(
    parameter int CNT_W = 17
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              go,
    input  lcd_pkg::win_cfg_t cfg,
    input  logic              wr_busy,
    input  logic              wr_done,
    output logic              req_start,
    output lcd_pkg::bus_req_t req,
    output logic              busy,
    output logic              done
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_CASET,
        SEND_PASET,
        SEND_RAMWR,
        SEND_PIXEL,
        WAIT,
        FINISH
    } state_t;

    state_t              state;
    state_t              ret_q;      // where to go after wr_done
    lcd_pkg::win_cfg_t   win_q;
    logic [CNT_W-1:0]    pix_cnt_q;
    lcd_pkg::coord_t     width;
    lcd_pkg::coord_t     height;
    logic [31:0]         area;
    logic                sending;

    assign width  = cfg.x1 - cfg.x0 + 16'd1;
    assign height = cfg.y1 - cfg.y0 + 16'd1;
    assign area   = width * height;

    assign sending = (state == SEND_CASET) || (state == SEND_PASET) ||
                     (state == SEND_RAMWR) || (state == SEND_PIXEL);

    assign req_start = sending && !wr_busy;
    assign busy      = (state != IDLE);
    assign done      = (state == FINISH);

    always_comb begin
        req = '0;
        case (state)
            SEND_CASET: begin
                req.cmd      = lcd_pkg::CMD_CASET;
                req.params   = {win_q.x0, win_q.x1};
                req.n_params = 3'd4;
            end
            SEND_PASET: begin
                req.cmd      = lcd_pkg::CMD_PASET;
                req.params   = {win_q.y0, win_q.y1};
                req.n_params = 3'd4;
            end
            SEND_RAMWR: begin
                req.cmd      = lcd_pkg::CMD_RAMWR;
                req.n_params = 3'd0;
            end
            SEND_PIXEL: begin
                req.params    = {win_q.colour, 16'h0000}; // high byte first
                req.n_params  = 3'd2;
                req.data_only = 1'b1;
            end
            default: begin
                req = '0;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state     <= IDLE;
            ret_q     <= IDLE;
            win_q     <= '0;
            pix_cnt_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (go) begin
                        state     <= SEND_CASET;
                        win_q     <= cfg;
                        pix_cnt_q <= area[CNT_W-1:0];
                    end
                end
                SEND_CASET, SEND_PASET, SEND_RAMWR: begin
                    if (!wr_busy) begin
                        state <= WAIT;
                        if (state == SEND_CASET) ret_q <= SEND_PASET;
                        else if (state == SEND_PASET) ret_q <= SEND_RAMWR;
                        else ret_q <= SEND_PIXEL;
                    end
                end
                SEND_PIXEL: begin
                    if (!wr_busy) begin
                        state     <= WAIT;
                        pix_cnt_q <= pix_cnt_q - 1'b1;
                        ret_q     <= (pix_cnt_q == 1) ? FINISH : SEND_PIXEL;
                    end
                end
                WAIT: begin
                    if (wr_done) begin
                        state <= ret_q;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/lcd_fill_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_fill_top #(
    parameter int CNT_W = 17
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               cfg_wr,
    input  lcd_pkg::reg_addr_t cfg_addr,
    input  logic [15:0]        cfg_wdata,
    input  logic               go,
    output logic               busy,
    output logic               done,
    output lcd_pkg::lcd_bus_t  lcd
);

    lcd_pkg::win_cfg_t cfg;
    lcd_pkg::bus_req_t req;
    logic              req_start;
    logic              wr_busy;
    logic              wr_done;

    lcd_cfg_regs u_cfg_regs (
        .clk       (clk),
        .nrst      (nrst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .cfg       (cfg)
    );

    lcd_fill_seq #(
        .CNT_W (CNT_W)
    ) u_fill_seq (
        .clk       (clk),
        .nrst      (nrst),
        .go        (go),
        .cfg       (cfg),
        .wr_busy   (wr_busy),
        .wr_done   (wr_done),
        .req_start (req_start),
        .req       (req),
        .busy      (busy),
        .done      (done)
    );

    lcd_bus_writer u_bus_writer (
        .clk       (clk),
        .nrst      (nrst),
        .req_start (req_start),
        .req       (req),
        .wr_busy   (wr_busy),
        .wr_done   (wr_done),
        .bus       (lcd)
    );

endmodule

`default_nettype wire

// File: testbench/lcd_fill_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_fill_tb;

    localparam logic [7:0] CASET_CODE = 8'h2A;
    localparam logic [7:0] PASET_CODE = 8'h2B;
    localparam logic [7:0] RAMWR_CODE = 8'h2C;
    localparam int         N_ROWS     = 5;

    logic               clk;
    logic               nrst;
    logic               cfg_wr;
    lcd_pkg::reg_addr_t cfg_addr;
    logic [15:0]        cfg_wdata;
    logic               go;
    logic               busy;
    logic               done;
    lcd_pkg::lcd_bus_t  lcd;

    lcd_pkg::win_cfg_t rows [N_ROWS];   // x0 x1 y0 y1 colour
    logic [8:0]        got_q [$];       // {dcx, data} per wrx rising edge
    logic [8:0]        exp_q [$];
    logic              wrx_prev = 1'b1;
    int                done_cnt;
    int                errors;
    int                cycles;
    int                cycle_limit;
    int                tests_passed;
    int                tests_failed;
    logic [31:0]       rnd;

    lcd_fill_top #(
        .CNT_W (17)
    ) UUT (
        .clk       (clk),
        .nrst      (nrst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .go        (go),
        .busy      (busy),
        .done      (done),
        .lcd       (lcd)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the fill never finished", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // panel bus monitor
    always @(negedge clk) begin
        if (nrst) begin
            if (!wrx_prev && lcd.wrx) begin
                got_q.push_back({lcd.dcx, lcd.data});
            end
            if (done) begin
                done_cnt = done_cnt + 1;
            end
            assert (busy || lcd.csx) else begin
                $display("** Error: csx got 0x%h expected 0x1 while busy is low", lcd.csx);
                errors = errors + 1;
            end
        end
        wrx_prev = lcd.wrx;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int window_area(input lcd_pkg::win_cfg_t w);
        return (int'(w.x1) - int'(w.x0) + 1) * (int'(w.y1) - int'(w.y0) + 1);
    endfunction

    task automatic build_expected(input lcd_pkg::win_cfg_t w);
        exp_q.delete();
        exp_q.push_back({1'b0, CASET_CODE});
        exp_q.push_back({1'b1, w.x0[15:8]});
        exp_q.push_back({1'b1, w.x0[7:0]});
        exp_q.push_back({1'b1, w.x1[15:8]});
        exp_q.push_back({1'b1, w.x1[7:0]});
        exp_q.push_back({1'b0, PASET_CODE});
        exp_q.push_back({1'b1, w.y0[15:8]});
        exp_q.push_back({1'b1, w.y0[7:0]});
        exp_q.push_back({1'b1, w.y1[15:8]});
        exp_q.push_back({1'b1, w.y1[7:0]});
        exp_q.push_back({1'b0, RAMWR_CODE});
        for (int p = 0; p < window_area(w); p++) begin
            exp_q.push_back({1'b1, w.colour[15:8]});
            exp_q.push_back({1'b1, w.colour[7:0]});
        end
    endtask

    task automatic write_reg(input lcd_pkg::reg_addr_t addr, input logic [15:0] value);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = value;
        @(negedge clk);
        cfg_wr    = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed = tests_passed + 1;
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAILED with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic check_reset_state();
        int err_start;
        err_start = errors;
        repeat (3) @(negedge clk);
        assert (lcd.csx && lcd.wrx) else begin
            $display("** Error: csx/wrx got 0x%h/0x%h expected 0x1/0x1", lcd.csx, lcd.wrx);
            errors = errors + 1;
        end
        assert (!busy && !done) else begin
            $display("** Error: busy/done got 0x%h/0x%h expected 0x0/0x0", busy, done);
            errors = errors + 1;
        end
        assert (got_q.size() == 0) else begin
            $display("wrx toggled %0d times after reset with no fill running", got_q.size());
            errors = errors + 1;
        end
        report_test("reset", err_start);
    endtask

    task automatic run_fill(input int idx);
        lcd_pkg::win_cfg_t w;
        int                err_start;
        w = rows[idx];
        err_start = errors;
        write_reg(lcd_pkg::REG_X0, w.x0);
        write_reg(lcd_pkg::REG_X1, w.x1);
        write_reg(lcd_pkg::REG_Y0, w.y0);
        write_reg(lcd_pkg::REG_Y1, w.y1);
        write_reg(lcd_pkg::REG_COLOUR, w.colour);
        build_expected(w);
        got_q.delete();
        done_cnt = 0;
        go = 1'b1;
        @(negedge clk);
        go = 1'b0;
        write_reg(lcd_pkg::REG_COLOUR, ~w.colour); // dropped while busy
        while (!done) begin
            assert (busy) else begin
                $display("** Error: busy got 0x%h expected 0x1 before done", busy);
                errors = errors + 1;
            end
            @(negedge clk);
        end
        @(negedge clk);
        assert (!busy) else begin
            $display("** Error: busy got 0x%h expected 0x0 after done", busy);
            errors = errors + 1;
        end
        assert (UUT.cfg.colour == w.colour) else begin
            $display("** Error: cfg.colour got 0x%h expected 0x%h", UUT.cfg.colour, w.colour);
            errors = errors + 1;
        end
        repeat (2) @(negedge clk);
        assert (done_cnt == 1) else begin
            $display("** Error: done pulses got 0x%h expected 0x1", done_cnt);
            errors = errors + 1;
        end
        assert (got_q.size() == exp_q.size()) else begin
            $display("** Error: byte count got 0x%h expected 0x%h", got_q.size(), exp_q.size());
            errors = errors + 1;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i][7:0] == exp_q[i][7:0]) else begin
                $display("** Error: data[%0d] got 0x%h expected 0x%h",
                         i, got_q[i][7:0], exp_q[i][7:0]);
                errors = errors + 1;
            end
            assert (got_q[i][8] == exp_q[i][8]) else begin
                $display("** Error: dcx[%0d] got 0x%h expected 0x%h", i, got_q[i][8], exp_q[i][8]);
                errors = errors + 1;
            end
        end
        report_test($sformatf("fill %0d (%0d pixels)", idx, window_area(w)), err_start);
    endtask

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        go           = 1'b0;
        errors       = 0;
        done_cnt     = 0;
        cycles       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rnd          = 32'd12889;

        rows[0] = {16'd5, 16'd5, 16'd7, 16'd7, 16'hF800};                 // single pixel
        rows[1] = {16'd10, 16'd12, 16'd20, 16'd21, 16'h07E0};             // 3 x 2
        rows[2] = {16'h0101, 16'h0102, 16'h012C, 16'h012F, 16'h001F};     // 2 x 4 above 255
        rnd = xorshift32(rnd);
        rows[3] = {16'd0, 16'd3, 16'd0, 16'd1, rnd[15:0]};
        rnd = xorshift32(rnd);
        rows[4] = {16'd200, 16'd201, 16'd300, 16'd302, rnd[15:0]};

        cycle_limit = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            // 11 + 2 bytes and 3 + 1 requests per pixel
            cycle_limit = cycle_limit + 2 * (11 + 2 * window_area(rows[r]))
                                      + 3 * (3 + window_area(rows[r]));
        end
        cycle_limit = 2 * cycle_limit + 200;

        repeat (2) @(negedge clk);
        nrst = 1'b1;
        check_reset_state();
        for (int r = 0; r < N_ROWS; r++) begin
            run_fill(r);
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lcd_fill.f
source/lcd_pkg.sv
source/lcd_cfg_regs.sv
source/lcd_bus_writer.sv
source/lcd_fill_seq.sv
source/lcd_fill_top.sv
testbench/lcd_fill_tb.sv

// File: run_sim.sh
#!/bin/bash
# build the testbench with Verilator, run it and look for the pass line in the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f lcd_fill.f \
    --top-module lcd_fill_tb -o lcd_fill_sim \
    && ./obj_dir/lcd_fill_sim | tee sim.log \
    && grep -qx "sim passed" sim.log \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }
